// ==== mpu_settings.svh ====
`ifndef MPU_SETTINGS_SVH
`define MPU_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////

// Address and data width of core and bus ports
`define MPU_ADDR_W 32

// Number of programmable protection regions
`define MPU_PMP_REGIONS 4

// Bus transactions allowed in flight at once
`define MPU_MAX_OUTSTANDING 4

////////////////////////////////////////////////////////////
// Fixed attribute table
////////////////////////////////////////////////////////////

// Main memory is cacheable and bufferable, misaligned access allowed
`define MPU_PMA_MAIN_BASE 32'h0000_0000
`define MPU_PMA_MAIN_END 32'h0000_FFFF

// I/O space is bufferable only, misaligned access faults
`define MPU_PMA_IO_BASE 32'h1000_0000
`define MPU_PMA_IO_END 32'h1000_FFFF

`endif

// ==== mpu_pkg.sv ====
`include "mpu_settings.svh"

package mpu_pkg;

  // Status returned with every core response
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RD_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  // Privilege levels seen by the protection check
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } mpu_priv_e;

  // Fault record carried in the response data word
  typedef struct packed {
    logic                    attr_err;
    logic                    prot_err;
    logic [`MPU_ADDR_W-3:0]  addr_lo;
  } mpu_fault_rec_t;

  // Response word is read data on OK, fault record on a fault status
  typedef union packed {
    logic [`MPU_ADDR_W-1:0] rdata;
    mpu_fault_rec_t         fault;
  } mpu_resp_data_u;

  // Region matching modes, 2'b10 (NA4) is not supported
  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  // Region configuration byte in the usual pmpcfg layout
  typedef struct packed {
    logic      lock;
    logic [1:0] rsvd;
    pmp_mode_e mode;
    logic      x;
    logic      w;
    logic      r;
  } pmp_cfg_t;

endpackage

// ==== mpu_chk_if.sv ====
`include "mpu_settings.svh"

// One request's attributes out to the checkers, verdicts back to the FSM
interface mpu_chk_if;

  // Request side, driven by the top from the core port
  logic [`MPU_ADDR_W-1:0] addr;
  logic                   we;
  logic                   misaligned;

  // Verdicts
  logic                   pma_err;
  logic                   pmp_err;
  logic                   cacheable;
  logic                   bufferable;

  // Attribute table lookup
  modport pma (
    input  addr, misaligned,
    output pma_err, cacheable, bufferable
  );

  // Region protection check
  modport pmp (
    input  addr, we,
    output pmp_err
  );

  // Fault FSM sees everything
  modport fsm (
    input addr, we, misaligned, pma_err, pmp_err, cacheable, bufferable
  );

endinterface

// ==== mpu_pma.sv ====
`include "mpu_settings.svh"

module mpu_pma (
  mpu_chk_if.pma chk
);

  localparam int AW = `MPU_ADDR_W;

  // Range sizes, both bounds inclusive
  localparam logic [AW-1:0] MAIN_SPAN = `MPU_PMA_MAIN_END - `MPU_PMA_MAIN_BASE;
  localparam logic [AW-1:0] IO_SPAN   = `MPU_PMA_IO_END - `MPU_PMA_IO_BASE;

  logic [AW-1:0] main_off;
  logic [AW-1:0] io_off;
  logic          in_main;
  logic          in_io;

  ////////////////////////////////////////////////////////////
  // Range decode
  ////////////////////////////////////////////////////////////

  // Offset into each range, wraps to a large value below the base
  assign main_off = chk.addr - `MPU_PMA_MAIN_BASE;
  assign io_off   = chk.addr - `MPU_PMA_IO_BASE;

  assign in_main = (main_off <= MAIN_SPAN);
  assign in_io   = (io_off <= IO_SPAN);

  ////////////////////////////////////////////////////////////
  // Attributes
  ////////////////////////////////////////////////////////////

  // Only main memory may be cached
  assign chk.cacheable  = in_main;
  // Both regions accept buffered writes
  assign chk.bufferable = in_main || in_io;

  // Unmapped address, or a split access into I/O space
  assign chk.pma_err = !(in_main || in_io) || (in_io && chk.misaligned);

endmodule

// ==== mpu_pmp.sv ====
`include "mpu_settings.svh"

module mpu_pmp (
  input  logic                   clk,
  input  logic                   rst_n,
  mpu_chk_if.pmp                 chk,
  input  mpu_pkg::pmp_cfg_t      pmp_cfg_i [`MPU_PMP_REGIONS],
  input  logic [`MPU_ADDR_W-1:0] pmp_addr_i [`MPU_PMP_REGIONS],
  input  mpu_pkg::mpu_priv_e     priv_lvl_i
);

  import mpu_pkg::*;

  localparam int AW = `MPU_ADDR_W;
  localparam int NR = `MPU_PMP_REGIONS;

  logic [AW-1:0] word_addr;
  logic [AW-1:0] tor_base [NR];
  logic [AW-1:0] napot_mask [NR];
  logic [NR-1:0] region_hit;
  logic          hit;
  pmp_cfg_t      hit_cfg;
  logic          perm_ok;

  // Region registers hold address bits [33:2]
  assign word_addr = {2'b00, chk.addr[AW-1:2]};

  ////////////////////////////////////////////////////////////
  // Per-region match
  ////////////////////////////////////////////////////////////

  always_comb begin : region_match
    // TOR base is the previous region's address, zero below region 0
    tor_base[0] = '0;
    for (int i = 1; i < NR; i++) begin
      tor_base[i] = pmp_addr_i[i-1];
    end

    for (int i = 0; i < NR; i++) begin
      // Trailing ones of the address select the NAPOT size
      napot_mask[i] = ~(pmp_addr_i[i] ^ (pmp_addr_i[i] + AW'(1)));

      case (pmp_cfg_i[i].mode)
        PMP_TOR: begin
          region_hit[i] = (word_addr >= tor_base[i]) && (word_addr < pmp_addr_i[i]);
        end
        PMP_NAPOT: begin
          region_hit[i] = (word_addr & napot_mask[i]) == (pmp_addr_i[i] & napot_mask[i]);
        end
        // OFF never matches
        default: region_hit[i] = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Priority and privilege
  ////////////////////////////////////////////////////////////

  always_comb begin : region_select
    hit     = 1'b0;
    hit_cfg = '0;

    // Walk downwards so the lowest matching index wins
    for (int i = NR - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        hit     = 1'b1;
        hit_cfg = pmp_cfg_i[i];
      end
    end

    perm_ok = chk.we ? hit_cfg.w : hit_cfg.r;

    if (priv_lvl_i == PRIV_M) begin
      // Machine mode is only held back by locked regions
      chk.pmp_err = hit && hit_cfg.lock && !perm_ok;
    end else begin
      // User mode needs a region that grants the access
      chk.pmp_err = !hit || !perm_ok;
    end
  end

  // CSR side must never program the unsupported NA4 encoding
  for (genvar g = 0; g < NR; g++) begin : g_mode_chk
    a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
      pmp_cfg_i[g].mode inside {PMP_OFF, PMP_TOR, PMP_NAPOT});
  end

endmodule

// ==== mpu_txn_counter.sv ====
`include "mpu_settings.svh"

module mpu_txn_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic bus_req_fire_i,
  input  logic bus_resp_valid_i,
  output logic drained_o,
  output logic full_o
);

  localparam int CW = $clog2(`MPU_MAX_OUTSTANDING + 1);
  localparam logic [CW-1:0] CNT_MAX = CW'(`MPU_MAX_OUTSTANDING);

  logic [CW-1:0] cnt_q;

  // Requests up, responses down, both at once cancel out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({bus_req_fire_i, bus_resp_valid_i})
        2'b10:   cnt_q <= cnt_q + CW'(1);
        2'b01:   cnt_q <= cnt_q - CW'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Nothing left after this cycle
  assign drained_o = (cnt_q == '0) || ((cnt_q == CW'(1)) && bus_resp_valid_i);
  assign full_o    = (cnt_q == CNT_MAX);

  // A wrapped count lands above the limit
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= CNT_MAX);

  // Bus side only answers requests it has seen
  a_no_resp_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
    bus_resp_valid_i |-> (cnt_q != '0));

endmodule

// ==== mpu_err_fsm.sv ====
`include "mpu_settings.svh"

module mpu_err_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  mpu_chk_if.fsm                 chk,
  input  logic                   core_req_valid_i,
  output logic                   core_req_ready_o,
  output logic                   bus_req_valid_o,
  input  logic                   bus_req_ready_i,
  input  logic                   bus_resp_valid_i,
  input  logic [`MPU_ADDR_W-1:0] bus_resp_rdata_i,
  input  logic                   drained_i,
  input  logic                   full_i,
  output logic                   core_resp_valid_o,
  output mpu_pkg::mpu_status_e   core_resp_status_o,
  output mpu_pkg::mpu_resp_data_u core_resp_data_o
);

  import mpu_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    RD_WAIT,
    WR_WAIT,
    RD_RESP,
    WR_RESP
  } state_e;

  state_e         state_q;
  state_e         state_d;
  logic           mpu_err;
  logic           block_core;
  logic           block_bus;
  logic           err_ready;
  logic           err_valid;
  mpu_status_e    err_status;
  mpu_fault_rec_t fault_q;

  assign mpu_err = chk.pma_err || chk.pmp_err;

  ////////////////////////////////////////////////////////////
  // Fault consuming FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    block_core = 1'b0;
    block_bus  = 1'b0;
    err_ready  = 1'b0;
    err_valid  = 1'b0;
    err_status = MPU_OK;

    case (state_q)
      IDLE: begin
        if (core_req_valid_i && mpu_err) begin
          // Swallow the request, it never reaches the bus
          block_bus = 1'b1;
          err_ready = 1'b1;
          if (chk.we) begin
            state_d = drained_i ? WR_RESP : WR_WAIT;
          end else begin
            state_d = drained_i ? RD_RESP : RD_WAIT;
          end
        end
      end
      RD_WAIT, WR_WAIT: begin
        // Hold off new traffic until older responses are back
        block_bus  = 1'b1;
        block_core = 1'b1;
        if (drained_i) begin
          state_d = (state_q == RD_WAIT) ? RD_RESP : WR_RESP;
        end
      end
      RD_RESP, WR_RESP: begin
        block_bus  = 1'b1;
        block_core = 1'b1;
        err_valid  = 1'b1;
        err_status = (state_q == RD_RESP) ? MPU_RD_FAULT : MPU_WR_FAULT;
        // core is always ready for a response
        state_d    = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Fault record captured when the bad request is consumed
  always_ff @(posedge clk) begin
    if (err_ready) begin
      fault_q.attr_err <= chk.pma_err;
      fault_q.prot_err <= chk.pmp_err;
      fault_q.addr_lo  <= chk.addr[`MPU_ADDR_W-3:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Request gating and response merge
  ////////////////////////////////////////////////////////////

  // Full counter also holds back the bus so nothing is accepted twice
  assign bus_req_valid_o  = core_req_valid_i && !block_bus && !full_i;
  assign core_req_ready_o = (bus_req_ready_i && !block_core && !full_i) || err_ready;

  assign core_resp_valid_o  = bus_resp_valid_i || err_valid;
  assign core_resp_status_o = err_status;

  always_comb begin
    core_resp_data_o.rdata = bus_resp_rdata_i;
    if (err_valid) begin
      core_resp_data_o.fault = fault_q;
    end
  end

  // Draining guarantees the fault slot is free of bus traffic
  a_resp_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(err_valid && bus_resp_valid_i));

endmodule

// ==== mpu_top.sv ====
`include "mpu_settings.svh"

module mpu_top (
  input  logic                    clk,
  input  logic                    rst_n,
  // Core request
  input  logic                    core_req_valid_i,
  output logic                    core_req_ready_o,
  input  logic [`MPU_ADDR_W-1:0]  core_req_addr_i,
  input  logic                    core_req_we_i,
  input  logic [`MPU_ADDR_W-1:0]  core_req_wdata_i,
  input  logic                    core_req_misaligned_i,
  // Protection state
  input  mpu_pkg::mpu_priv_e      priv_lvl_i,
  input  mpu_pkg::pmp_cfg_t       pmp_cfg_i [`MPU_PMP_REGIONS],
  input  logic [`MPU_ADDR_W-1:0]  pmp_addr_i [`MPU_PMP_REGIONS],
  // Bus request
  output logic                    bus_req_valid_o,
  input  logic                    bus_req_ready_i,
  output logic [`MPU_ADDR_W-1:0]  bus_req_addr_o,
  output logic                    bus_req_we_o,
  output logic [`MPU_ADDR_W-1:0]  bus_req_wdata_o,
  output logic [1:0]              bus_req_memtype_o,
  // Responses
  input  logic                    bus_resp_valid_i,
  input  logic [`MPU_ADDR_W-1:0]  bus_resp_rdata_i,
  output logic                    core_resp_valid_o,
  output mpu_pkg::mpu_status_e    core_resp_status_o,
  output mpu_pkg::mpu_resp_data_u core_resp_data_o
);

  logic bus_req_fire;
  logic drained;
  logic full;

  mpu_chk_if i_chk ();

  // Request attributes into the checkers
  assign i_chk.addr       = core_req_addr_i;
  assign i_chk.we         = core_req_we_i;
  assign i_chk.misaligned = core_req_misaligned_i;

  // Payload passes straight to the bus
  assign bus_req_addr_o    = core_req_addr_i;
  assign bus_req_we_o      = core_req_we_i;
  assign bus_req_wdata_o   = core_req_wdata_i;
  // Memtype bit 1 cacheable, bit 0 bufferable
  assign bus_req_memtype_o = {i_chk.cacheable, i_chk.bufferable};

  assign bus_req_fire = bus_req_valid_o && bus_req_ready_i;

  mpu_pma i_pma (
    .chk (i_chk)
  );

  mpu_pmp i_pmp (
    .clk        (clk),
    .rst_n      (rst_n),
    .chk        (i_chk),
    .pmp_cfg_i  (pmp_cfg_i),
    .pmp_addr_i (pmp_addr_i),
    .priv_lvl_i (priv_lvl_i)
  );

  mpu_txn_counter i_txn_counter (
    .clk              (clk),
    .rst_n            (rst_n),
    .bus_req_fire_i   (bus_req_fire),
    .bus_resp_valid_i (bus_resp_valid_i),
    .drained_o        (drained),
    .full_o           (full)
  );

  mpu_err_fsm i_err_fsm (
    .clk                (clk),
    .rst_n              (rst_n),
    .chk                (i_chk),
    .core_req_valid_i   (core_req_valid_i),
    .core_req_ready_o   (core_req_ready_o),
    .bus_req_valid_o    (bus_req_valid_o),
    .bus_req_ready_i    (bus_req_ready_i),
    .bus_resp_valid_i   (bus_resp_valid_i),
    .bus_resp_rdata_i   (bus_resp_rdata_i),
    .drained_i          (drained),
    .full_i             (full),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_status_o (core_resp_status_o),
    .core_resp_data_o   (core_resp_data_o)
  );

endmodule

// ==== tb_mpu.sv ====
`include "mpu_settings.svh"

module tb_mpu;

  timeunit 1ns;
  timeprecision 100ps;

  import mpu_pkg::*;

  localparam int AW = `MPU_ADDR_W;
  localparam int NR = `MPU_PMP_REGIONS;
  // Bus model read data is the address scrambled with this key
  localparam logic [AW-1:0] RDATA_KEY = 32'hA5A5_5A5A;
  localparam int CYCLES_PER_LINE = 200;

  // One stimulus line with the region 0 config in the low byte of cfg
  typedef struct packed {
    logic                   we;
    logic [1:0]             priv;
    logic                   mis;
    logic [AW-1:0]          addr;
    logic [AW-1:0]          wdata;
    logic [31:0]            cfg;
    logic [NR-1:0][AW-1:0]  paddr;
    logic [1:0]             status;
    logic [1:0]             memtype;
    logic [AW-1:0]          fault;
  } stim_t;

  typedef struct packed {
    logic [1:0]    status;
    logic          chk_data;
    logic [AW-1:0] data;
  } exp_resp_t;

  // Accepted bus request waiting for its response slot
  typedef struct packed {
    logic [AW-1:0] rdata;
    logic [31:0]   due;
  } bus_pend_t;

  logic           clk;
  logic           rst_n;
  logic           core_req_valid;
  logic           core_req_ready;
  logic [AW-1:0]  core_req_addr;
  logic           core_req_we;
  logic [AW-1:0]  core_req_wdata;
  logic           core_req_misaligned;
  mpu_priv_e      priv_lvl;
  pmp_cfg_t       pmp_cfg [NR];
  logic [AW-1:0]  pmp_addr [NR];
  logic           bus_req_valid;
  logic           bus_req_ready;
  logic [AW-1:0]  bus_req_addr;
  logic           bus_req_we;
  logic [AW-1:0]  bus_req_wdata;
  logic [1:0]     bus_req_memtype;
  logic           bus_resp_valid;
  logic [AW-1:0]  bus_resp_rdata;
  logic           core_resp_valid;
  mpu_status_e    core_resp_status;
  mpu_resp_data_u core_resp_data;

  stim_t       stim [$];
  stim_t       cur;
  exp_resp_t   exp_q [$];
  bus_pend_t   bus_q [$];
  logic [31:0] cycle = '0;
  logic [31:0] lfsr_q = 32'hfef6ea39;
  logic        fault_pending = 1'b0;
  logic        fault_due = 1'b0;
  logic        loaded = 1'b0;

  mpu_top i_mpu_top (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .core_req_valid_i      (core_req_valid),
    .core_req_ready_o      (core_req_ready),
    .core_req_addr_i       (core_req_addr),
    .core_req_we_i         (core_req_we),
    .core_req_wdata_i      (core_req_wdata),
    .core_req_misaligned_i (core_req_misaligned),
    .priv_lvl_i            (priv_lvl),
    .pmp_cfg_i             (pmp_cfg),
    .pmp_addr_i            (pmp_addr),
    .bus_req_valid_o       (bus_req_valid),
    .bus_req_ready_i       (bus_req_ready),
    .bus_req_addr_o        (bus_req_addr),
    .bus_req_we_o          (bus_req_we),
    .bus_req_wdata_o       (bus_req_wdata),
    .bus_req_memtype_o     (bus_req_memtype),
    .bus_resp_valid_i      (bus_resp_valid),
    .bus_resp_rdata_i      (bus_resp_rdata),
    .core_resp_valid_o     (core_resp_valid),
    .core_resp_status_o    (core_resp_status),
    .core_resp_data_o      (core_resp_data)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR stepped once for every bit handed out
  function automatic logic [3:0] take_bits(input int n);
    logic [3:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits   = {bits[2:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return bits;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    stim_t       s;
    logic [31:0] col [13];
    fd = $fopen("mpu_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open mpu_stimulus.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // Skip column notes and blank lines
      if (line.len() < 8 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                  col[2], col[3], col[4], col[5], col[6], col[7], col[8], col[9],
                  col[10], col[11], col[12]);
      if (n != 13) begin
        abort_run($sformatf("Stimulus line could not be parsed: %s", line));
      end
      s.we      = col[0][0];
      s.priv    = col[1][1:0];
      s.mis     = col[2][0];
      s.addr    = col[3];
      s.wdata   = col[4];
      s.cfg     = col[5];
      for (int i = 0; i < NR; i++) begin
        s.paddr[i] = col[6+i];
      end
      s.status  = col[10][1:0];
      s.memtype = col[11][1:0];
      s.fault   = col[12];
      stim.push_back(s);
    end
    $fclose(fd);
  endtask

  task automatic apply_request(input stim_t s);
    cur                 = s;
    core_req_valid      = 1'b1;
    core_req_we         = s.we;
    core_req_misaligned = s.mis;
    core_req_addr       = s.addr;
    core_req_wdata      = s.wdata;
    priv_lvl            = mpu_priv_e'(s.priv);
    for (int i = 0; i < NR; i++) begin
      pmp_cfg[i]  = pmp_cfg_t'(s.cfg[8*i +: 8]);
      pmp_addr[i] = s.paddr[i];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : main_seq
    rst_n               = 1'b0;
    core_req_valid      = 1'b0;
    core_req_addr       = '0;
    core_req_we         = 1'b0;
    core_req_wdata      = '0;
    core_req_misaligned = 1'b0;
    priv_lvl            = PRIV_M;
    bus_req_ready       = 1'b0;
    bus_resp_valid      = 1'b0;
    bus_resp_rdata      = '0;
    cur                 = '0;
    for (int i = 0; i < NR; i++) begin
      pmp_cfg[i]  = '0;
      pmp_addr[i] = '0;
    end
    load_stimulus();
    loaded = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    foreach (stim[i]) begin
      @(negedge clk);
      apply_request(stim[i]);
      // Core holds the request until it is taken
      @(posedge clk);
      while (!core_req_ready) @(posedge clk);
    end
    @(negedge clk);
    core_req_valid = 1'b0;
    while (exp_q.size() != 0 || bus_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("Done: no errors");
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    repeat (16 + stim.size() * CYCLES_PER_LINE) @(posedge clk);
    abort_run("Timeout, the DUT stopped answering requests");
  end

  ////////////////////////////////////////////////////////////
  // Bus responder model
  ////////////////////////////////////////////////////////////

  // Random back-pressure and in-order responses once their slot is due
  always @(negedge clk) begin : bus_responder
    bus_pend_t pend;
    bus_req_ready = (take_bits(2) != 4'd0);
    if (bus_q.size() != 0 && bus_q[0].due <= cycle) begin
      pend           = bus_q.pop_front();
      bus_resp_valid = 1'b1;
      bus_resp_rdata = pend.rdata;
    end else begin
      bus_resp_valid = 1'b0;
      bus_resp_rdata = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitor and scoreboard
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    exp_resp_t er;
    exp_resp_t got;
    bus_pend_t pend;
    int        inflight;
    cycle = cycle + 32'd1;
    if (rst_n) begin
      // Bus transactions still counted by the DUT before this edge
      inflight = bus_q.size() + int'(bus_resp_valid);
      if (fault_pending) begin
        // Closed from the cycle after the fault through its response
        check_val("core_req_ready_o", 32'(core_req_ready), 32'd0);
        check_val("bus_req_valid_o", 32'(bus_req_valid), 32'd0);
        // Fault answer is due one cycle after the last bus response
        if (fault_due) begin
          check_val("core_resp_valid_o", 32'(core_resp_valid), 32'd1);
        end
      end else if (core_req_valid && cur.status == 2'd0) begin
        // Ready follows the bus unless the in-flight limit is reached
        check_val("core_req_ready_o", 32'(core_req_ready),
                  32'(bus_req_ready && inflight < `MPU_MAX_OUTSTANDING));
      end else if (core_req_valid) begin
        // A faulting request is taken in its own cycle
        check_val("core_req_ready_o", 32'(core_req_ready), 32'd1);
      end
      // A faulting request must never show up as bus valid
      if (core_req_valid && cur.status != 2'd0) begin
        check_val("bus_req_valid_o", 32'(bus_req_valid), 32'd0);
      end
      if (bus_req_valid && bus_req_ready) begin
        // Answer 1 to 4 cycles after acceptance
        pend.rdata = bus_req_addr ^ RDATA_KEY;
        pend.due   = cycle + 32'(take_bits(2));
        bus_q.push_back(pend);
      end
      if (core_req_valid && core_req_ready) begin
        if (cur.status == 2'd0) begin
          check_val("bus_req_valid_o", 32'(bus_req_valid), 32'd1);
          check_val("bus_req_addr_o", bus_req_addr, cur.addr);
          check_val("bus_req_we_o", 32'(bus_req_we), 32'(cur.we));
          check_val("bus_req_wdata_o", bus_req_wdata, cur.wdata);
          check_val("bus_req_memtype_o", 32'(bus_req_memtype), 32'(cur.memtype));
          er.status   = 2'd0;
          er.chk_data = !cur.we;
          er.data     = cur.addr ^ RDATA_KEY;
        end else begin
          fault_pending = 1'b1;
          er.status     = cur.status;
          er.chk_data   = 1'b1;
          er.data       = cur.fault;
        end
        exp_q.push_back(er);
      end
      if (core_resp_valid) begin
        if (exp_q.size() == 0) begin
          abort_run("A core response arrived with no request outstanding");
        end
        got = exp_q.pop_front();
        check_val("core_resp_status_o", 32'(core_resp_status), 32'(got.status));
        // Data word decoded by status
        if (got.chk_data && got.status == 2'd0) begin
          check_val("core_resp_data_o.rdata", core_resp_data.rdata, got.data);
        end else if (got.chk_data) begin
          check_val("core_resp_data_o.fault", 32'(core_resp_data.fault), got.data);
        end
        if (got.status != 2'd0) begin
          fault_pending = 1'b0;
        end
      end
      // Nothing left on the bus after this cycle
      fault_due = fault_pending && (bus_q.size() == 0);
    end
  end

endmodule

// ==== mpu_stimulus.txt ====
# we priv mis addr wdata cfg(r3..r0) paddr0 paddr1 paddr2 paddr3 status memtype fault
# priv 0 user 3 machine, status 0 ok 1 read fault 2 write fault, all values hex
0 0 0 00000100 00000000 0000000B 04004000 00000000 00000000 00000000 0 3 00000000
1 0 0 10000010 CAFE0001 0000000B 04004000 00000000 00000000 00000000 0 1 00000000
0 0 0 10000040 00000000 0000000B 04004000 00000000 00000000 00000000 0 1 00000000
1 0 1 00000203 12345678 0000000B 04004000 00000000 00000000 00000000 0 3 00000000
0 3 0 20000000 00000000 0000000B 04004000 00000000 00000000 00000000 1 0 A0000000
1 3 1 10000022 0000BEEF 0000000B 04004000 00000000 00000000 00000000 2 0 90000022
0 0 0 20000000 00000000 0000000B 04004000 00000000 00000000 00000000 1 0 E0000000
1 3 0 00010000 00C0FFEE 0000000B 04004000 00000000 00000000 00000000 2 0 80010000
0 0 0 00008004 00000000 00000019 000021FF 00000000 00000000 00000000 0 3 00000000
1 0 0 00008010 5A5A0001 00000019 000021FF 00000000 00000000 00000000 2 0 40008010
0 0 0 00004000 00000000 00000019 000021FF 00000000 00000000 00000000 1 0 40004000
0 3 0 00004000 00000000 00000019 000021FF 00000000 00000000 00000000 0 3 00000000
1 3 0 00008010 5A5A0002 00000019 000021FF 00000000 00000000 00000000 0 3 00000000
1 3 0 00008010 5A5A0003 00000099 000021FF 00000000 00000000 00000000 2 0 40008010
0 3 0 00008020 00000000 00000099 000021FF 00000000 00000000 00000000 0 3 00000000
1 0 0 10000010 11110000 00000B00 04000000 04004000 00000000 00000000 0 1 00000000
0 0 0 00000100 00000000 00000B00 04000000 04004000 00000000 00000000 1 0 40000100
0 0 0 00008004 00000000 00000B18 000021FF 04004000 00000000 00000000 1 0 40008004
0 0 0 00009000 00000000 00000B18 000021FF 04004000 00000000 00000000 0 3 00000000
0 0 0 00000010 00000000 0000000B 04004000 00000000 00000000 00000000 0 3 00000000
1 0 0 10000100 22220001 0000000B 04004000 00000000 00000000 00000000 0 1 00000000
0 0 0 00000020 00000000 0000000B 04004000 00000000 00000000 00000000 0 3 00000000
1 0 0 10000104 22220002 0000000B 04004000 00000000 00000000 00000000 0 1 00000000
1 3 0 30000000 33330000 0000000B 04004000 00000000 00000000 00000000 2 0 B0000000
0 0 0 00000030 00000000 0000000B 04004000 00000000 00000000 00000000 0 3 00000000
0 0 0 0000FFFC 00000000 0000000B 04004000 00000000 00000000 00000000 0 3 00000000
0 3 0 40000000 00000000 0000000B 04004000 00000000 00000000 00000000 1 0 80000000

// ==== project.f ====
+incdir+.
mpu_pkg.sv
mpu_chk_if.sv
mpu_pma.sv
mpu_pmp.sv
mpu_txn_counter.sv
mpu_err_fsm.sv
mpu_top.sv
tb_mpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the MPU testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mpu -f project.f -o tb_mpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mpu_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0
